//--- common/secv_pkg.sv
// Core-wide data width, hart id width and their vector types
package secv_pkg;

    localparam int XLEN   = 64;             // RV64 only
    localparam int HART_W = 4;              // Up to 16 harts addressable

    typedef logic [XLEN-1:0]   xlen_t;      // Register values, PCs, addresses
    typedef logic [HART_W-1:0] hart_id_t;   // Hardware thread id

endpackage

//--- common/csr_pkg.sv
// CSR addresses, funct3 codes, cause codes, mstatus and interrupt bit positions, identity values
package csr_pkg;

    typedef logic [11:0] csr_adr_t;         // CSR address field of the instruction
    typedef logic [2:0]  csr_funct3_t;      // Instruction funct3
    typedef logic [5:0]  cause_t;           // Exception or interrupt code
    typedef logic [2:0]  irq_vec_t;         // {mei, mti, msi}

    // Machine status and control
    localparam csr_adr_t CSR_ADR_MSTATUS    = 12'h300;
    localparam csr_adr_t CSR_ADR_MISA       = 12'h301;
    localparam csr_adr_t CSR_ADR_MIE        = 12'h304;
    localparam csr_adr_t CSR_ADR_MTVEC      = 12'h305;
    localparam csr_adr_t CSR_ADR_MCOUNTEREN = 12'h306;
    // Machine trap handling
    localparam csr_adr_t CSR_ADR_MSCRATCH   = 12'h340;
    localparam csr_adr_t CSR_ADR_MEPC       = 12'h341;
    localparam csr_adr_t CSR_ADR_MCAUSE     = 12'h342;
    localparam csr_adr_t CSR_ADR_MTVAL      = 12'h343;
    localparam csr_adr_t CSR_ADR_MIP        = 12'h344;
    // Counters
    localparam csr_adr_t CSR_ADR_MCYCLE     = 12'hB00;
    localparam csr_adr_t CSR_ADR_MINSTRET   = 12'hB02;
    // Identity, read-only space
    localparam csr_adr_t CSR_ADR_MVENDORID  = 12'hF11;
    localparam csr_adr_t CSR_ADR_MARCHID    = 12'hF12;
    localparam csr_adr_t CSR_ADR_MIMPID     = 12'hF13;
    localparam csr_adr_t CSR_ADR_MHARTID    = 12'hF14;

    localparam csr_funct3_t F3_CSRRW  = 3'b001;
    localparam csr_funct3_t F3_CSRRS  = 3'b010;
    localparam csr_funct3_t F3_CSRRC  = 3'b011;
    localparam csr_funct3_t F3_CSRRWI = 3'b101;
    localparam csr_funct3_t F3_CSRRSI = 3'b110;
    localparam csr_funct3_t F3_CSRRCI = 3'b111;

    // Interrupt codes, equal to the mie/mip bit positions
    localparam cause_t IRQ_MSI = 6'd3;
    localparam cause_t IRQ_MTI = 6'd7;
    localparam cause_t IRQ_MEI = 6'd11;

    // Index into irq_vec_t
    localparam int IRQV_MSI = 0;
    localparam int IRQV_MTI = 1;
    localparam int IRQV_MEI = 2;

    localparam cause_t EX_ILLEGAL     = 6'd2;
    localparam cause_t EX_BREAKPOINT  = 6'd3;
    localparam cause_t EX_LD_MISALIGN = 6'd4;
    localparam cause_t EX_LD_FAULT    = 6'd5;
    localparam cause_t EX_ST_MISALIGN = 6'd6;
    localparam cause_t EX_ST_FAULT    = 6'd7;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;     // MPP is bits 12:11
    localparam int MSTATUS_MPP_HI = 12;
    localparam logic [1:0] PRIV_MACHINE = 2'b11;

    // MXL = 2 (RV64), extension I only
    localparam secv_pkg::xlen_t MISA_VALUE = 64'h8000_0000_0000_0100;
    localparam secv_pkg::xlen_t MVENDORID  = '0; // Non-commercial
    localparam secv_pkg::xlen_t MARCHID    = '0;
    localparam secv_pkg::xlen_t MIMPID     = '0;

endpackage

//--- common/csr_if.sv
// Interface for one CSR read-modify-write access, decoder to register file
`timescale 1ns/1ps

interface csr_if;

    csr_pkg::csr_adr_t adr;     // CSR address
    logic              re;      // Read enable
    logic              we;      // Write enable, takes effect at next edge
    secv_pkg::xlen_t   wdat;    // New value
    secv_pkg::xlen_t   rdat;    // Old value, combinational

    modport master (
        output adr, re, we, wdat,
        input  rdat
    );

    modport slave (
        input  adr, re, we, wdat,
        output rdat
    );

endinterface

//--- common/trap_if.sv
// Interface for trap decision and trap state between register file and trap controller
`timescale 1ns/1ps

interface trap_if;

    // State from the register file
    logic                mstatus_mie;   // Global interrupt enable
    csr_pkg::irq_vec_t   mie_vec;       // Per-source enables
    secv_pkg::xlen_t     mtvec;         // Base and mode
    secv_pkg::xlen_t     mepc;          // Return address

    // Decision from the controller, one-cycle strobes
    logic                take_irq;
    logic                take_ex;
    csr_pkg::cause_t     cause;         // Valid with take_irq or take_ex
    logic                mret;

    modport regs (
        output mstatus_mie, mie_vec, mtvec, mepc,
        input  take_irq, take_ex, cause, mret
    );

    modport ctrl (
        input  mstatus_mie, mie_vec, mtvec, mepc,
        output take_irq, take_ex, cause, mret
    );

endinterface

//--- hw/csr/csr_access.sv
// CSR instruction decoder with read-modify-write value and illegal access check
`timescale 1ns/1ps

module csr_access (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 csr_valid_i,    // CSR instruction in this cycle
    input  csr_pkg::csr_funct3_t csr_funct3_i,
    input  csr_pkg::csr_adr_t    csr_adr_i,
    input  secv_pkg::xlen_t      csr_src_i,      // rs1 data or zero-extended uimm
    output logic                 csr_illegal_o,
    output secv_pkg::xlen_t      rd_dat_o,       // Old CSR value
    csr_if.master                bus
);

    logic [1:0] op;         // 01 write, 10 set, 11 clear, 00 reserved
    logic       wr_intent;  // Instruction would modify the CSR
    logic       ro_adr;     // Top address bits 11 mark read-only space

    assign op     = csr_funct3_i[1:0]; // Immediate forms share the low bits
    assign ro_adr = (csr_adr_i[11:10] == 2'b11);

    // Set/clear with a zero source is a pure read
    assign wr_intent = (op == 2'b01) || (op != 2'b00 && csr_src_i != '0);

    // funct3 0 and 4 both decode to op 00
    assign csr_illegal_o = csr_valid_i && (op == 2'b00 || (wr_intent && ro_adr));

    assign bus.adr = csr_adr_i;
    assign bus.re  = csr_valid_i;
    assign bus.we  = csr_valid_i && wr_intent && !ro_adr; // Writable space only

    always_comb begin
        case (op)
            2'b01:   bus.wdat = csr_src_i;               // CSRRW(I)
            2'b10:   bus.wdat = bus.rdat | csr_src_i;    // CSRRS(I)
            2'b11:   bus.wdat = bus.rdat & ~csr_src_i;   // CSRRC(I)
            default: bus.wdat = bus.rdat;
        endcase
    end

    assign rd_dat_o = bus.rdat;

    // Illegal access must never reach the register file as a write
    a_illegal_no_we: assert property (
        @(posedge clk_i) disable iff (rst_i) csr_illegal_o |-> !bus.we
    ) else $error("Illegal CSR access raised a write");

endmodule

//--- hw/csr/csr_regs.sv
// Machine CSR storage, trap entry and mret updates, counters and read multiplexer
`timescale 1ns/1ps

module csr_regs (
    input  logic                clk_i,
    input  logic                rst_i,
    input  secv_pkg::hart_id_t  hartid_i,
    input  csr_pkg::irq_vec_t   irq_pend_i,     // Level, becomes mip
    input  logic                retire_i,       // One instruction retired
    input  secv_pkg::xlen_t     trap_pc_i,      // PC of the trapping instruction
    input  secv_pkg::xlen_t     trap_adr_i,     // Faulting memory address
    csr_if.slave                bus,
    trap_if.regs                trap
);

    localparam int XLEN = secv_pkg::XLEN;

    // Place {mei, mti, msi} at their mie/mip bit positions
    function automatic secv_pkg::xlen_t irq_to_reg(csr_pkg::irq_vec_t v);
        secv_pkg::xlen_t r;
        r = '0;
        r[csr_pkg::IRQ_MSI] = v[csr_pkg::IRQV_MSI];
        r[csr_pkg::IRQ_MTI] = v[csr_pkg::IRQV_MTI];
        r[csr_pkg::IRQ_MEI] = v[csr_pkg::IRQV_MEI];
        return r;
    endfunction

    logic              st_mie;      // mstatus.MIE
    logic              st_mpie;     // mstatus.MPIE
    logic [1:0]        st_mpp;      // mstatus.MPP, machine after first trap
    csr_pkg::irq_vec_t mie;
    secv_pkg::xlen_t   mtvec;
    secv_pkg::xlen_t   mscratch;
    secv_pkg::xlen_t   mepc;
    logic              mcause_irq;  // mcause interrupt flag, bit XLEN-1
    csr_pkg::cause_t   mcause_code;
    secv_pkg::xlen_t   mtval;
    secv_pkg::xlen_t   mcycle;
    secv_pkg::xlen_t   minstret;
    secv_pkg::xlen_t   mstatus;     // Assembled view
    logic              trap_now;
    logic              mem_cause;   // Cause carries an address in mtval

    assign trap_now  = trap.take_irq || trap.take_ex;
    assign mem_cause = trap.take_ex && (trap.cause == csr_pkg::EX_LD_MISALIGN ||
                                        trap.cause == csr_pkg::EX_LD_FAULT    ||
                                        trap.cause == csr_pkg::EX_ST_MISALIGN ||
                                        trap.cause == csr_pkg::EX_ST_FAULT);

    always_comb begin
        mstatus = '0;
        mstatus[csr_pkg::MSTATUS_MIE]  = st_mie;
        mstatus[csr_pkg::MSTATUS_MPIE] = st_mpie;
        mstatus[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = st_mpp;
    end

    // Status, enables, trap state; trap strobes win over CSR writes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            st_mie      <= 1'b0;
            st_mpie     <= 1'b0;
            st_mpp      <= 2'b00;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
            mtval       <= '0;
        end else if (trap_now) begin
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            st_mpp      <= csr_pkg::PRIV_MACHINE;
            mepc        <= trap_pc_i;
            mcause_irq  <= trap.take_irq;
            mcause_code <= trap.cause;
            mtval       <= mem_cause ? trap_adr_i : '0;
        end else if (trap.mret) begin
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
        end else if (bus.we) begin
            case (bus.adr)
                csr_pkg::CSR_ADR_MSTATUS: begin // Only MIE and MPIE writable
                    st_mie  <= bus.wdat[csr_pkg::MSTATUS_MIE];
                    st_mpie <= bus.wdat[csr_pkg::MSTATUS_MPIE];
                end
                csr_pkg::CSR_ADR_MIE: begin
                    mie[csr_pkg::IRQV_MSI] <= bus.wdat[csr_pkg::IRQ_MSI];
                    mie[csr_pkg::IRQV_MTI] <= bus.wdat[csr_pkg::IRQ_MTI];
                    mie[csr_pkg::IRQV_MEI] <= bus.wdat[csr_pkg::IRQ_MEI];
                end
                csr_pkg::CSR_ADR_MTVEC:    mtvec    <= {bus.wdat[XLEN-1:2], 1'b0, bus.wdat[0]};
                csr_pkg::CSR_ADR_MSCRATCH: mscratch <= bus.wdat;
                csr_pkg::CSR_ADR_MEPC:     mepc     <= {bus.wdat[XLEN-1:1], 1'b0};
                csr_pkg::CSR_ADR_MCAUSE: begin
                    mcause_irq  <= bus.wdat[XLEN-1];
                    mcause_code <= bus.wdat[5:0];
                end
                csr_pkg::CSR_ADR_MTVAL:    mtval    <= bus.wdat;
                default: ;                 // Read-only or unimplemented
            endcase
        end
    end

    // Free-running counters, a CSR write overrides the increment
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (bus.we && bus.adr == csr_pkg::CSR_ADR_MCYCLE)
                mcycle <= bus.wdat;
            else
                mcycle <= mcycle + 1'b1;
            if (bus.we && bus.adr == csr_pkg::CSR_ADR_MINSTRET)
                minstret <= bus.wdat;
            else if (retire_i)
                minstret <= minstret + 1'b1;
        end
    end

    // Read mux, old values
    always_comb begin
        bus.rdat = '0;
        if (bus.re) begin
            case (bus.adr)
                csr_pkg::CSR_ADR_MSTATUS:    bus.rdat = mstatus;
                csr_pkg::CSR_ADR_MISA:       bus.rdat = csr_pkg::MISA_VALUE;
                csr_pkg::CSR_ADR_MIE:        bus.rdat = irq_to_reg(mie);
                csr_pkg::CSR_ADR_MTVEC:      bus.rdat = mtvec;
                csr_pkg::CSR_ADR_MCOUNTEREN: bus.rdat = '0;   // No counter enables
                csr_pkg::CSR_ADR_MSCRATCH:   bus.rdat = mscratch;
                csr_pkg::CSR_ADR_MEPC:       bus.rdat = mepc;
                csr_pkg::CSR_ADR_MCAUSE:     bus.rdat = {mcause_irq, {(XLEN-7){1'b0}}, mcause_code};
                csr_pkg::CSR_ADR_MTVAL:      bus.rdat = mtval;
                csr_pkg::CSR_ADR_MIP:        bus.rdat = irq_to_reg(irq_pend_i);
                csr_pkg::CSR_ADR_MCYCLE:     bus.rdat = mcycle;
                csr_pkg::CSR_ADR_MINSTRET:   bus.rdat = minstret;
                csr_pkg::CSR_ADR_MVENDORID:  bus.rdat = csr_pkg::MVENDORID;
                csr_pkg::CSR_ADR_MARCHID:    bus.rdat = csr_pkg::MARCHID;
                csr_pkg::CSR_ADR_MIMPID:     bus.rdat = csr_pkg::MIMPID;
                csr_pkg::CSR_ADR_MHARTID:
                    bus.rdat = {{(XLEN-secv_pkg::HART_W){1'b0}}, hartid_i};
                default:                     bus.rdat = '0;
            endcase
        end
    end

    assign trap.mstatus_mie = st_mie;
    assign trap.mie_vec     = mie;
    assign trap.mtvec       = mtvec;
    assign trap.mepc        = mepc;

    // Controller must never issue two state changes at one edge
    a_strobe_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $onehot0({trap.take_irq, trap.take_ex, trap.mret})
    ) else $error("Trap and mret strobes overlap");

endmodule

//--- hw/csr/trap_ctrl.sv
// Interrupt selection, trap decision, trap vector and return PC
`timescale 1ns/1ps

module trap_ctrl (
    input  logic              ex_i,         // Synchronous exception
    input  csr_pkg::cause_t   ex_cause_i,
    input  logic              mret_i,
    input  csr_pkg::irq_vec_t irq_pend_i,   // Level inputs {mei, mti, msi}
    output logic              trap_o,
    output secv_pkg::xlen_t   trap_vec_o,   // Next PC on a trap
    output secv_pkg::xlen_t   mret_pc_o,    // Next PC on mret
    trap_if.ctrl              trap
);

    csr_pkg::irq_vec_t irq_act;     // Pending, enabled, globally allowed
    csr_pkg::cause_t   irq_cause;
    secv_pkg::xlen_t   base;

    assign irq_act = irq_pend_i & trap.mie_vec & {3{trap.mstatus_mie}};

    // Fixed priority MEI > MSI > MTI
    always_comb begin
        if (irq_act[csr_pkg::IRQV_MEI])
            irq_cause = csr_pkg::IRQ_MEI;
        else if (irq_act[csr_pkg::IRQV_MSI])
            irq_cause = csr_pkg::IRQ_MSI;
        else
            irq_cause = csr_pkg::IRQ_MTI;
    end

    assign trap.take_ex  = ex_i;                      // Exceptions first
    assign trap.take_irq = !ex_i && (irq_act != '0);
    assign trap.cause    = ex_i ? ex_cause_i : irq_cause;
    assign trap.mret     = mret_i && !trap_o;         // Trap suppresses mret

    assign trap_o = trap.take_ex || trap.take_irq;

    // Vectored mode only for interrupts
    assign base = {trap.mtvec[secv_pkg::XLEN-1:2], 2'b00};
    assign trap_vec_o = (trap.take_irq && trap.mtvec[0])
                      ? base + {trap.cause, 2'b00}
                      : base;

    assign mret_pc_o = trap.mepc;

endmodule

//--- hw/csr_unit.sv
// Machine-mode CSR unit top level: decoder, register file and trap controller
`timescale 1ns/1ps

module csr_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  secv_pkg::hart_id_t   hartid_i,
    // CSR instruction
    input  logic                 csr_valid_i,
    input  csr_pkg::csr_funct3_t csr_funct3_i,
    input  csr_pkg::csr_adr_t    csr_adr_i,
    input  secv_pkg::xlen_t      csr_src_i,
    output secv_pkg::xlen_t      rd_dat_o,
    output logic                 csr_illegal_o,
    // Traps
    input  csr_pkg::irq_vec_t    irq_pend_i,
    input  logic                 ex_i,
    input  csr_pkg::cause_t      ex_cause_i,
    input  secv_pkg::xlen_t      trap_pc_i,
    input  secv_pkg::xlen_t      trap_adr_i,
    input  logic                 mret_i,
    input  logic                 retire_i,
    output logic                 trap_o,
    output secv_pkg::xlen_t      trap_vec_o,
    output secv_pkg::xlen_t      mret_pc_o
);

    csr_if  csr_bus ();
    trap_if trap_bus ();

    csr_access u_access (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_valid_i   (csr_valid_i),
        .csr_funct3_i  (csr_funct3_i),
        .csr_adr_i     (csr_adr_i),
        .csr_src_i     (csr_src_i),
        .csr_illegal_o (csr_illegal_o),
        .rd_dat_o      (rd_dat_o),
        .bus           (csr_bus.master)
    );

    csr_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .hartid_i   (hartid_i),
        .irq_pend_i (irq_pend_i),
        .retire_i   (retire_i),
        .trap_pc_i  (trap_pc_i),
        .trap_adr_i (trap_adr_i),
        .bus        (csr_bus.slave),
        .trap       (trap_bus.regs)
    );

    trap_ctrl u_trap (
        .ex_i       (ex_i),
        .ex_cause_i (ex_cause_i),
        .mret_i     (mret_i),
        .irq_pend_i (irq_pend_i),
        .trap_o     (trap_o),
        .trap_vec_o (trap_vec_o),
        .mret_pc_o  (mret_pc_o),
        .trap       (trap_bus.ctrl)
    );

endmodule

//--- verif/csr_unit_tb.sv
// Testbench for csr_unit with step table, LCG data, clock, reset, checks and timeout
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int CLK_HALF  = 50;          // 100 ns period
    localparam int CHECK_DLY = 90;          // Sample 10 ns before the next edge
    localparam secv_pkg::hart_id_t HART_ID   = 4'h5;
    localparam secv_pkg::xlen_t    HART_WORD = 64'd5;

    // How rd_dat_o is judged in a step
    localparam logic [1:0] RD_NONE  = 2'd0;
    localparam logic [1:0] RD_EXACT = 2'd1;
    localparam logic [1:0] RD_MARK  = 2'd2; // Remember the value
    localparam logic [1:0] RD_DELTA = 2'd3; // Value minus remembered one

    typedef struct packed {
        logic                 valid;
        csr_pkg::csr_funct3_t funct3;
        csr_pkg::csr_adr_t    adr;
        secv_pkg::xlen_t      src;
        csr_pkg::irq_vec_t    irq;
        logic                 ex;
        csr_pkg::cause_t      cause;
        logic                 mret;
        secv_pkg::xlen_t      pc;
        secv_pkg::xlen_t      tadr;
        logic [1:0]           rd_kind;
        secv_pkg::xlen_t      exp_rd;   // Value or cycle gap for RD_DELTA
        logic                 exp_ill;
        logic                 exp_trap;
        secv_pkg::xlen_t      exp_pc;   // trap_vec_o on a trap or mret_pc_o on mret
    } step_t;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    secv_pkg::hart_id_t   hartid_i;
    logic                 csr_valid_i;
    csr_pkg::csr_funct3_t csr_funct3_i;
    csr_pkg::csr_adr_t    csr_adr_i;
    secv_pkg::xlen_t      csr_src_i;
    secv_pkg::xlen_t      rd_dat_o;
    logic                 csr_illegal_o;
    csr_pkg::irq_vec_t    irq_pend_i;
    logic                 ex_i;
    csr_pkg::cause_t      ex_cause_i;
    secv_pkg::xlen_t      trap_pc_i;
    secv_pkg::xlen_t      trap_adr_i;
    logic                 mret_i;
    logic                 retire_i;
    logic                 trap_o;
    secv_pkg::xlen_t      trap_vec_o;
    secv_pkg::xlen_t      mret_pc_o;

    step_t           steps[$];
    logic [31:0]     lcg_state;
    secv_pkg::xlen_t mark_val;              // mcycle at the RD_MARK step
    int              err_cnt     = 0;
    int              check_cnt   = 0;
    int              cycle_cnt   = 0;
    int              cycle_limit = 1000;    // Replaced once the table exists

    csr_unit dut0 (.*);

    always #CLK_HALF clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Error: run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function secv_pkg::xlen_t rand64();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    function automatic secv_pkg::xlen_t mstatus_word(logic mie, logic mpie, logic [1:0] mpp);
        secv_pkg::xlen_t w;
        w = '0;
        w[csr_pkg::MSTATUS_MIE]  = mie;
        w[csr_pkg::MSTATUS_MPIE] = mpie;
        w[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = mpp;
        return w;
    endfunction

    function automatic step_t csr_op(csr_pkg::csr_funct3_t f3, csr_pkg::csr_adr_t adr,
                                     secv_pkg::xlen_t src, logic [1:0] kind,
                                     secv_pkg::xlen_t exp_rd, logic exp_ill);
        step_t s;
        s = '0;
        s.valid   = 1'b1;
        s.funct3  = f3;
        s.adr     = adr;
        s.src     = src;
        s.rd_kind = kind;
        s.exp_rd  = exp_rd;
        s.exp_ill = exp_ill;
        return s;
    endfunction

    // Pure read as a set with zero source
    function automatic step_t read_op(csr_pkg::csr_adr_t adr, secv_pkg::xlen_t exp_rd);
        return csr_op(csr_pkg::F3_CSRRS, adr, '0, RD_EXACT, exp_rd, 1'b0);
    endfunction

    function automatic step_t rmw_op(csr_pkg::csr_funct3_t f3, secv_pkg::xlen_t src,
                                     secv_pkg::xlen_t exp_rd);
        return csr_op(f3, csr_pkg::CSR_ADR_MSCRATCH, src, RD_EXACT, exp_rd, 1'b0);
    endfunction

    function automatic step_t trap_op(csr_pkg::irq_vec_t irq, logic ex, csr_pkg::cause_t cause,
                                      secv_pkg::xlen_t pc, secv_pkg::xlen_t tadr,
                                      logic exp_trap, secv_pkg::xlen_t exp_vec);
        step_t s;
        s = '0;
        s.irq      = irq;
        s.ex       = ex;
        s.cause    = cause;
        s.pc       = pc;
        s.tadr     = tadr;
        s.exp_trap = exp_trap;
        s.exp_pc   = exp_vec;
        return s;
    endfunction

    task automatic drive_step(step_t s);
        csr_valid_i  <= s.valid;
        csr_funct3_i <= s.funct3;
        csr_adr_i    <= s.adr;
        csr_src_i    <= s.src;
        irq_pend_i   <= s.irq;
        ex_i         <= s.ex;
        ex_cause_i   <= s.cause;
        mret_i       <= s.mret;
        trap_pc_i    <= s.pc;
        trap_adr_i   <= s.tadr;
    endtask

    task automatic check_step(int idx, step_t s);
        secv_pkg::xlen_t delta;
        check_cnt += 2;
        assert (trap_o === s.exp_trap) else begin
            err_cnt++;
            $display("Mismatch at %0t: step %0d trap_o %b, expected %b",
                     $time, idx, trap_o, s.exp_trap);
        end
        assert (csr_illegal_o === s.exp_ill) else begin
            err_cnt++;
            $display("Mismatch at %0t: step %0d csr_illegal_o %b, expected %b",
                     $time, idx, csr_illegal_o, s.exp_ill);
        end
        if (s.exp_trap) begin
            check_cnt++;
            assert (trap_vec_o === s.exp_pc) else begin
                err_cnt++;
                $display("Mismatch at %0t: step %0d trap_vec_o %h, expected %h",
                         $time, idx, trap_vec_o, s.exp_pc);
            end
        end
        if (s.mret) begin
            check_cnt++;
            assert (mret_pc_o === s.exp_pc) else begin
                err_cnt++;
                $display("Mismatch at %0t: step %0d mret_pc_o %h, expected %h",
                         $time, idx, mret_pc_o, s.exp_pc);
            end
        end
        case (s.rd_kind)
            RD_EXACT: begin
                check_cnt++;
                assert (rd_dat_o === s.exp_rd) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: step %0d rd_dat_o %h, expected %h",
                             $time, idx, rd_dat_o, s.exp_rd);
                end
            end
            RD_MARK:  mark_val = rd_dat_o;
            RD_DELTA: begin
                check_cnt++;
                delta = rd_dat_o - mark_val;
                assert (delta === s.exp_rd) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: step %0d counter advanced %0d, expected %0d",
                             $time, idx, delta, s.exp_rd);
                end
            end
            RD_NONE:  ;
            default:  ;
        endcase
    endtask

    initial begin
        secv_pkg::xlen_t m;
        secv_pkg::xlen_t d;
        secv_pkg::xlen_t p1;
        secv_pkg::xlen_t p2;
        secv_pkg::xlen_t p3;
        secv_pkg::xlen_t a1;
        secv_pkg::xlen_t base_d;
        secv_pkg::xlen_t base_v;
        secv_pkg::xlen_t all_irq;
        step_t s;
        rst_i     = 1'b1;
        hartid_i  = HART_ID;
        retire_i  = 1'b0;
        s         = '0;
        drive_step(s);
        lcg_state = 32'hecaf_ef1f;
        base_d    = 64'h0000_0000_8000_0100;    // Direct mode
        base_v    = 64'h0000_0000_8000_0200;    // Vectored base without the mode bit
        all_irq   = (64'h1 << csr_pkg::IRQ_MSI) | (64'h1 << csr_pkg::IRQ_MTI) |
                    (64'h1 << csr_pkg::IRQ_MEI);

        // Reset values and identity
        steps.push_back(read_op(csr_pkg::CSR_ADR_MSTATUS, '0));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MIE, '0));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MEPC, '0));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MISA, csr_pkg::MISA_VALUE));
        // m follows the mscratch content through the RMW steps
        d = rand64();
        steps.push_back(rmw_op(csr_pkg::F3_CSRRW, d, '0));
        m = d;
        d = rand64();
        steps.push_back(rmw_op(csr_pkg::F3_CSRRS, d, m));
        m = m | d;
        d = rand64();
        steps.push_back(rmw_op(csr_pkg::F3_CSRRC, d, m));
        m = m & ~d;
        steps.push_back(rmw_op(csr_pkg::F3_CSRRSI, 64'h15, m));
        m = m | 64'h15;
        steps.push_back(rmw_op(csr_pkg::F3_CSRRCI, 64'h0, m));    // Zero uimm is a pure read
        steps.push_back(rmw_op(csr_pkg::F3_CSRRWI, 64'h0a, m));
        m = 64'h0a;
        steps.push_back(read_op(csr_pkg::CSR_ADR_MSCRATCH, m));
        // Illegal writes to read-only space and reserved funct3
        d = rand64();
        steps.push_back(csr_op(csr_pkg::F3_CSRRW, csr_pkg::CSR_ADR_MHARTID, d, RD_EXACT,
                               HART_WORD, 1'b1));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MHARTID, HART_WORD));
        steps.push_back(csr_op(3'd4, csr_pkg::CSR_ADR_MSCRATCH, d, RD_EXACT, m, 1'b1));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MSCRATCH, m));
        // Load fault with MIE set
        steps.push_back(csr_op(csr_pkg::F3_CSRRW, csr_pkg::CSR_ADR_MTVEC, base_d, RD_EXACT,
                               '0, 1'b0));
        steps.push_back(csr_op(csr_pkg::F3_CSRRS, csr_pkg::CSR_ADR_MSTATUS,
                               mstatus_word(1'b1, 1'b0, 2'b00), RD_EXACT, '0, 1'b0));
        p1 = rand64() & ~64'h3;
        a1 = rand64();
        steps.push_back(trap_op(3'b000, 1'b1, csr_pkg::EX_LD_FAULT, p1, a1, 1'b1, base_d));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MEPC, p1));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MCAUSE, {{58{1'b0}}, csr_pkg::EX_LD_FAULT}));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MTVAL, a1));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MSTATUS,
                                mstatus_word(1'b0, 1'b1, csr_pkg::PRIV_MACHINE)));
        // Vectored interrupts
        steps.push_back(csr_op(csr_pkg::F3_CSRRW, csr_pkg::CSR_ADR_MTVEC, base_v | 64'h1,
                               RD_EXACT, base_d, 1'b0));
        steps.push_back(csr_op(csr_pkg::F3_CSRRW, csr_pkg::CSR_ADR_MIE, all_irq, RD_EXACT,
                               '0, 1'b0));
        // Pending lines ignored while the global enable is clear
        s = csr_op(csr_pkg::F3_CSRRS, csr_pkg::CSR_ADR_MSTATUS, mstatus_word(1'b1, 1'b0, 2'b00),
                   RD_EXACT, mstatus_word(1'b0, 1'b1, csr_pkg::PRIV_MACHINE), 1'b0);
        s.irq = 3'b111;
        steps.push_back(s);
        p2 = rand64() & ~64'h3;
        steps.push_back(trap_op(3'b011, 1'b0, '0, p2, '0, 1'b1,
                                base_v + 4 * csr_pkg::IRQ_MSI));  // MSI over MTI
        steps.push_back(read_op(csr_pkg::CSR_ADR_MCAUSE, {1'b1, {57{1'b0}}, csr_pkg::IRQ_MSI}));
        steps.push_back(read_op(csr_pkg::CSR_ADR_MEPC, p2));
        // mret returns to p2 and restores MIE from MPIE
        s = '0;
        s.mret   = 1'b1;
        s.exp_pc = p2;
        steps.push_back(s);
        steps.push_back(read_op(csr_pkg::CSR_ADR_MSTATUS,
                                mstatus_word(1'b1, 1'b1, csr_pkg::PRIV_MACHINE)));
        p3 = rand64() & ~64'h3;
        steps.push_back(trap_op(3'b111, 1'b0, '0, p3, '0, 1'b1,
                                base_v + 4 * csr_pkg::IRQ_MEI));  // MEI wins all
        steps.push_back(read_op(csr_pkg::CSR_ADR_MCAUSE, {1'b1, {57{1'b0}}, csr_pkg::IRQ_MEI}));
        // mip mirrors the lines and MIE is clear so no trap
        s = read_op(csr_pkg::CSR_ADR_MIP,
                    (64'h1 << csr_pkg::IRQ_MEI) | (64'h1 << csr_pkg::IRQ_MSI));
        s.irq = 3'b101;
        steps.push_back(s);
        // mcycle four steps apart
        steps.push_back(csr_op(csr_pkg::F3_CSRRS, csr_pkg::CSR_ADR_MCYCLE, '0, RD_MARK, '0, 1'b0));
        s = '0;
        repeat (3) steps.push_back(s);
        steps.push_back(csr_op(csr_pkg::F3_CSRRS, csr_pkg::CSR_ADR_MCYCLE, '0, RD_DELTA,
                               64'd4, 1'b0));

        cycle_limit = steps.size() + 20;

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk_i);
            drive_step(steps[i]);
            #CHECK_DLY;
            check_step(i, steps[i]);
        end
        @(posedge clk_i);
        s = '0;
        drive_step(s);

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
common/secv_pkg.sv
common/csr_pkg.sv
common/csr_if.sv
common/trap_if.sv
hw/csr/csr_access.sv
hw/csr/csr_regs.sv
hw/csr/trap_ctrl.sv
hw/csr_unit.sv
verif/csr_unit_tb.sv
